// File: core_ctrl_top.sv
////////////////////////////////////////
// trap and flow controller top level
////////////////////////////////////////

`timescale 1ns/1ps

module core_ctrl_top (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  ctrl_pkg::instr_t     instr_i,
  input  ctrl_pkg::dec_flags_t dec_i,
  input  trap_pkg::irqs_t      irqs_i,
  input  logic                 mie_i,
  input  ctrl_pkg::lsu_err_t   lsu_err_i,
  input  logic                 stall_id_i,
  output ctrl_pkg::pc_ctrl_t   pc_o,
  output trap_pkg::csr_ctrl_t  csr_o,
  output logic                 nmi_mode_o,
  output logic                 instr_req_o,
  output logic                 ctrl_busy_o,
  output logic                 id_in_ready_o,
  output logic                 instr_valid_clear_o,
  output logic                 flush_id_o
);

  // detector to pending register and FSM
  trap_pkg::trap_rec_t  trap_id;
  logic                 special_req;
  logic                 irq_take;
  trap_pkg::exc_cause_u irq_cause;

  // pending register to FSM and back
  trap_pkg::trap_rec_t  pending;
  logic                 trap_clear;

  trap_detect u_trap_detect (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .instr_i       (instr_i),
    .dec_i         (dec_i),
    .irqs_i        (irqs_i),
    .mie_i         (mie_i),
    .nmi_mode_i    (nmi_mode_o),
    .trap_o        (trap_id),
    .special_req_o (special_req),
    .irq_take_o    (irq_take),
    .irq_cause_o   (irq_cause)
  );

  trap_pending u_trap_pending (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .trap_i    (trap_id),
    .lsu_err_i (lsu_err_i),
    .clear_i   (trap_clear),
    .pending_o (pending)
  );

  ctrl_fsm u_ctrl_fsm (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .instr_i             (instr_i),
    .dec_i               (dec_i),
    .irqs_i              (irqs_i),
    .special_req_i       (special_req),
    .irq_take_i          (irq_take),
    .irq_cause_i         (irq_cause),
    .pending_i           (pending),
    .stall_id_i          (stall_id_i),
    .trap_clear_o        (trap_clear),
    .nmi_mode_o          (nmi_mode_o),
    .pc_o                (pc_o),
    .csr_o               (csr_o),
    .instr_req_o         (instr_req_o),
    .ctrl_busy_o         (ctrl_busy_o),
    .id_in_ready_o       (id_in_ready_o),
    .instr_valid_clear_o (instr_valid_clear_o),
    .flush_id_o          (flush_id_o)
  );

endmodule

// File: ctrl_defines.svh
////////////////////////////////////////
// widths and counts shared by the trap
// and flow controller
////////////////////////////////////////

`ifndef CTRL_DEFINES_SVH
`define CTRL_DEFINES_SVH

// data and address width
`define CTRL_XLEN 32

// fast interrupt lines
`define CTRL_NUM_FAST 15

// mcause word, irq flag plus code
`define CTRL_CAUSE_W 6

// fast interrupt index inside the cause word
`define CTRL_FAST_ID_W 4

`endif

// File: ctrl_fsm.sv
////////////////////////////////////////
// controller FSM, NMI mode, PC and CSR
// strobes, stall and flush control
////////////////////////////////////////

`timescale 1ns/1ps

module ctrl_fsm (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  ctrl_pkg::instr_t     instr_i,
  input  ctrl_pkg::dec_flags_t dec_i,
  input  trap_pkg::irqs_t      irqs_i,
  input  logic                 special_req_i,
  input  logic                 irq_take_i,
  input  trap_pkg::exc_cause_u irq_cause_i,
  input  trap_pkg::trap_rec_t  pending_i,
  input  logic                 stall_id_i,
  output logic                 trap_clear_o,
  output logic                 nmi_mode_o,
  output ctrl_pkg::pc_ctrl_t   pc_o,
  output trap_pkg::csr_ctrl_t  csr_o,
  output logic                 instr_req_o,
  output logic                 ctrl_busy_o,
  output logic                 id_in_ready_o,
  output logic                 instr_valid_clear_o,
  output logic                 flush_id_o
);

  ctrl_pkg::ctrl_state_e state_q;
  ctrl_pkg::ctrl_state_e state_d;

  logic nmi_mode_q;
  logic nmi_mode_d;

  logic halt_if;
  logic retain_id;
  logic flush_id;

  logic mret_insn;
  logic wfi_insn;
  logic wake;
  logic lsu_fault;

  assign mret_insn = dec_i.mret & instr_i.valid;
  assign wfi_insn  = dec_i.wfi & instr_i.valid;

  // sleep ends on any raw line, MIE plays no part here
  assign wake = |irqs_i;

  // LSU faults have no instruction in ID to save
  assign lsu_fault = ~pending_i.cause.exc_view.irq &
                     ((pending_i.cause.exc_view.code == trap_pkg::CAUSE_LOAD_FAULT[4:0]) |
                      (pending_i.cause.exc_view.code == trap_pkg::CAUSE_STORE_FAULT[4:0]));

  ////////////////////////////////////////
  // next state and outputs
  ////////////////////////////////////////

  always_comb begin
    state_d     = state_q;
    nmi_mode_d  = nmi_mode_q;
    instr_req_o = 1'b1;
    ctrl_busy_o = 1'b1;
    halt_if     = 1'b0;
    retain_id   = 1'b0;
    flush_id    = 1'b0;

    // mux values only count while set is high
    pc_o.set     = 1'b0;
    pc_o.mux     = ctrl_pkg::PC_BOOT;
    pc_o.exc_mux = ctrl_pkg::EXC_PC_EXC;

    csr_o.save_if      = 1'b0;
    csr_o.save_id      = 1'b0;
    csr_o.save_cause   = 1'b0;
    csr_o.restore_mret = 1'b0;
    csr_o.cause        = '0;
    csr_o.mtval        = '0;

    unique case (state_q)
      ctrl_pkg::RESET: begin
        // boot address loaded before fetch starts
        instr_req_o = 1'b0;
        pc_o.set    = 1'b1;
        state_d     = ctrl_pkg::BOOT_SET;
      end

      ctrl_pkg::BOOT_SET: begin
        pc_o.set = 1'b1;
        state_d  = ctrl_pkg::FIRST_FETCH;
      end

      ctrl_pkg::FIRST_FETCH: begin
        // hold IF while an interrupt waits for a stall to end
        halt_if = irq_take_i;
        if (!stall_id_i) begin
          state_d = irq_take_i ? ctrl_pkg::IRQ_TAKEN : ctrl_pkg::DECODE;
        end
      end

      ctrl_pkg::DECODE: begin
        if (special_req_i || pending_i.valid) begin
          // keep the instruction in ID for FLUSH
          retain_id = 1'b1;
          state_d   = ctrl_pkg::FLUSH;
        end else if (irq_take_i) begin
          // current instruction completes, IF gives nothing new
          halt_if = 1'b1;
          if (!stall_id_i) begin
            state_d = ctrl_pkg::IRQ_TAKEN;
          end
        end
      end

      ctrl_pkg::IRQ_TAKEN: begin
        pc_o.mux     = ctrl_pkg::PC_EXC;
        pc_o.exc_mux = ctrl_pkg::EXC_PC_IRQ;
        // the line may have dropped in the meantime
        if (irq_take_i) begin
          pc_o.set         = 1'b1;
          csr_o.save_if    = 1'b1;
          csr_o.save_cause = 1'b1;
          csr_o.cause      = irq_cause_i;
          // nm outranks every other line, so it is the one taken
          if (irqs_i.nm) begin
            nmi_mode_d = 1'b1;
          end
        end
        state_d = ctrl_pkg::DECODE;
      end

      ctrl_pkg::FLUSH: begin
        halt_if  = 1'b1;
        flush_id = 1'b1;
        state_d  = ctrl_pkg::DECODE;
        if (pending_i.valid) begin
          // trap entry, mepc from ID only for ID faults
          pc_o.set         = 1'b1;
          pc_o.mux         = ctrl_pkg::PC_EXC;
          pc_o.exc_mux     = ctrl_pkg::EXC_PC_EXC;
          csr_o.save_id    = ~lsu_fault;
          csr_o.save_cause = 1'b1;
          csr_o.cause      = pending_i.cause;
          csr_o.mtval      = pending_i.mtval;
        end else if (mret_insn) begin
          // return from handler, also leaves NMI mode
          pc_o.set           = 1'b1;
          pc_o.mux           = ctrl_pkg::PC_ERET;
          csr_o.restore_mret = 1'b1;
          nmi_mode_d         = 1'b0;
        end else if (wfi_insn) begin
          state_d = ctrl_pkg::WAIT_SLEEP;
        end
      end

      ctrl_pkg::WAIT_SLEEP: begin
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        halt_if     = 1'b1;
        flush_id    = 1'b1;
        state_d     = ctrl_pkg::SLEEP;
      end

      ctrl_pkg::SLEEP: begin
        instr_req_o = 1'b0;
        halt_if     = 1'b1;
        flush_id    = 1'b1;
        if (wake) begin
          state_d = ctrl_pkg::FIRST_FETCH;
        end else begin
          ctrl_busy_o = 1'b0;
        end
      end

      default: begin
        instr_req_o = 1'b0;
        state_d     = ctrl_pkg::RESET;
      end
    endcase
  end

  // pending records are consumed in FLUSH
  assign trap_clear_o = (state_q == ctrl_pkg::FLUSH);
  assign nmi_mode_o   = nmi_mode_q;
  assign flush_id_o   = flush_id;

  ////////////////////////////////////////
  // stall control
  ////////////////////////////////////////

  assign id_in_ready_o = ~stall_id_i & ~halt_if & ~retain_id;

  // retain_id keeps valid set unless a flush kills it
  assign instr_valid_clear_o = ~(stall_id_i | retain_id) | flush_id;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= ctrl_pkg::RESET;
      nmi_mode_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      nmi_mode_q <= nmi_mode_d;
    end
  end

  state_legal_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_q inside {ctrl_pkg::RESET, ctrl_pkg::BOOT_SET, ctrl_pkg::FIRST_FETCH,
                    ctrl_pkg::DECODE, ctrl_pkg::FLUSH, ctrl_pkg::IRQ_TAKEN,
                    ctrl_pkg::WAIT_SLEEP, ctrl_pkg::SLEEP});

  // a cause is only written together with a redirect to the trap vector
  save_cause_pc_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    csr_o.save_cause |-> pc_o.set && (pc_o.mux == ctrl_pkg::PC_EXC));

endmodule

// File: ctrl_pkg.sv
////////////////////////////////////////
// pipeline control types: FSM states,
// PC selectors, ID stage and LSU structs
////////////////////////////////////////

`include "ctrl_defines.svh"

package ctrl_pkg;

  typedef enum logic [3:0] {
    RESET,
    BOOT_SET,
    FIRST_FETCH,
    DECODE,
    FLUSH,
    IRQ_TAKEN,
    WAIT_SLEEP,
    SLEEP
  } ctrl_state_e;

  // fetch address source
  typedef enum logic [1:0] {
    PC_BOOT,
    PC_JUMP,
    PC_EXC,
    PC_ERET
  } pc_sel_e;

  // trap vector offset, exception or interrupt
  typedef enum logic {
    EXC_PC_EXC,
    EXC_PC_IRQ
  } exc_pc_sel_e;

  // instruction held in the IF/ID register
  typedef struct packed {
    logic                  valid;
    logic                  is_compressed;
    logic [`CTRL_XLEN-1:0] instr;
    logic [15:0]           instr_c;
    logic [`CTRL_XLEN-1:0] pc;
  } instr_t;

  // raw decoder flags, not yet qualified with valid
  typedef struct packed {
    logic illegal;
    logic ecall;
    logic ebrk;
    logic mret;
    logic wfi;
    logic fetch_err;
    logic fetch_err_plus2;
  } dec_flags_t;

  // single-cycle LSU error strobes with the faulting address
  typedef struct packed {
    logic                  load;
    logic                  store;
    logic [`CTRL_XLEN-1:0] addr;
  } lsu_err_t;

  typedef struct packed {
    logic        set;
    pc_sel_e     mux;
    exc_pc_sel_e exc_mux;
  } pc_ctrl_t;

endpackage

// File: src.f
+incdir+.
trap_pkg.sv
ctrl_pkg.sv
trap_detect.sv
trap_pending.sv
ctrl_fsm.sv
core_ctrl_top.sv
tb_core_ctrl.sv

// File: tb_core_ctrl.sv
////////////////////////////////////////
// table-driven testbench for the trap
// and flow controller, directed WFI test
////////////////////////////////////////

`timescale 1ns/1ps
`include "ctrl_defines.svh"

module tb_core_ctrl;

  localparam int NUM_ROWS  = 15;
  localparam int MAX_CYCLE = 12 * NUM_ROWS + 20;

  logic                 clk_i;
  logic                 rst_ni;
  ctrl_pkg::instr_t     instr_i;
  ctrl_pkg::dec_flags_t dec_i;
  trap_pkg::irqs_t      irqs_i;
  logic                 mie_i;
  ctrl_pkg::lsu_err_t   lsu_err_i;
  logic                 stall_id_i;
  ctrl_pkg::pc_ctrl_t   pc_o;
  trap_pkg::csr_ctrl_t  csr_o;
  logic                 nmi_mode_o;
  logic                 instr_req_o;
  logic                 ctrl_busy_o;
  logic                 id_in_ready_o;
  logic                 instr_valid_clear_o;
  logic                 flush_id_o;

  integer seed = 32'h2b4d_14f9;
  int     cycles = 0;
  int     nrows = 0;

  // stimulus columns
  string                 row_name  [NUM_ROWS];
  ctrl_pkg::instr_t      row_instr [NUM_ROWS];
  ctrl_pkg::dec_flags_t  row_dec   [NUM_ROWS];
  trap_pkg::irqs_t       row_irqs  [NUM_ROWS];
  logic                  row_mie   [NUM_ROWS];
  ctrl_pkg::lsu_err_t    row_lsu   [NUM_ROWS];
  logic                  row_stall [NUM_ROWS];
  int                    row_quiet [NUM_ROWS];
  // expected columns, flags are {save_if, save_id, save_cause, restore_mret}
  ctrl_pkg::pc_sel_e     row_pc    [NUM_ROWS];
  trap_pkg::exc_cause_u  row_cause [NUM_ROWS];
  logic [`CTRL_XLEN-1:0] row_mtval [NUM_ROWS];
  logic [3:0]            row_flags [NUM_ROWS];
  logic                  row_nmi   [NUM_ROWS];

  core_ctrl_top DUT (.*);

  always #20 clk_i = ~clk_i;

  // run limit
  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLE) begin
      $display("run stopped, the DUT gave no response within %0d cycles", MAX_CYCLE);
      $display("SIMULATION FAILED");
      $fatal(1, "timeout");
    end
  end

  ////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////

  task automatic fail_now();
    $display("SIMULATION FAILED");
    $fatal(1, "mismatch");
  endtask

  task automatic check_pc(string name, ctrl_pkg::pc_sel_e exp, ctrl_pkg::pc_sel_e act);
    if (exp !== act) begin
      $display("CHECK FAILED %s pc mux expected %s actual %s", name, exp.name(), act.name());
      fail_now();
    end
  endtask

  // both readings of the word must agree
  task automatic check_cause(string name, trap_pkg::exc_cause_u exp,
                             trap_pkg::exc_cause_u act);
    if (exp.exc_view !== act.exc_view || exp.irq_view !== act.irq_view) begin
      $display("CHECK FAILED %s cause expected %0h (irq %b fast %b id %0d) actual %0h",
               name, exp, exp.irq_view.irq, exp.irq_view.fast, exp.irq_view.id, act);
      fail_now();
    end
  endtask

  task automatic check_mtval(string name, logic [`CTRL_XLEN-1:0] exp,
                             logic [`CTRL_XLEN-1:0] act);
    if (exp !== act) begin
      $display("CHECK FAILED %s mtval expected %h actual %h", name, exp, act);
      fail_now();
    end
  endtask

  task automatic check_flag(string name, string what, logic exp, logic act);
    if (exp !== act) begin
      $display("CHECK FAILED %s %s expected %b actual %b", name, what, exp, act);
      fail_now();
    end
  endtask

  ////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////

  task automatic drive_idle();
    instr_i    <= '0;
    dec_i      <= '0;
    irqs_i     <= '0;
    mie_i      <= 1'b0;
    lsu_err_i  <= '0;
    stall_id_i <= 1'b0;
  endtask

  task automatic random_instr(input logic compressed, output ctrl_pkg::instr_t ins);
    ins               = '0;
    ins.valid         = 1'b1;
    ins.is_compressed = compressed;
    ins.instr         = $random(seed);
    ins.instr_c       = 16'($random(seed));
    ins.pc            = {$random(seed)} & 32'hffff_fffe;
  endtask

  task automatic add_row(string name, ctrl_pkg::instr_t ins, ctrl_pkg::dec_flags_t dec,
                         trap_pkg::irqs_t irqs, logic mie, ctrl_pkg::lsu_err_t lsu,
                         logic stall, int quiet, ctrl_pkg::pc_sel_e pc,
                         logic [5:0] cause, logic [`CTRL_XLEN-1:0] mtval,
                         logic [3:0] flags, logic nmi);
    row_name[nrows]  = name;
    row_instr[nrows] = ins;
    row_dec[nrows]   = dec;
    row_irqs[nrows]  = irqs;
    row_mie[nrows]   = mie;
    row_lsu[nrows]   = lsu;
    row_stall[nrows] = stall;
    row_quiet[nrows] = quiet;
    row_pc[nrows]    = pc;
    row_cause[nrows] = cause;
    row_mtval[nrows] = mtval;
    row_flags[nrows] = flags;
    row_nmi[nrows]   = nmi;
    nrows++;
  endtask

  task automatic build_table();
    ctrl_pkg::instr_t     ins;
    ctrl_pkg::dec_flags_t dec;
    trap_pkg::irqs_t      irq;
    ctrl_pkg::lsu_err_t   lsu;
    random_instr(1'b0, ins);
    dec = '0;
    dec.fetch_err = 1'b1;
    add_row("fetch_fault", ins, dec, '0, 1'b0, '0, 1'b0, 0, ctrl_pkg::PC_EXC,
            6'd1, ins.pc, 4'b0110, 1'b0);
    random_instr(1'b0, ins);
    dec.fetch_err_plus2 = 1'b1;
    add_row("fetch_fault_plus2", ins, dec, '0, 1'b0, '0, 1'b0, 0, ctrl_pkg::PC_EXC,
            6'd1, ins.pc + 32'd2, 4'b0110, 1'b0);
    random_instr(1'b0, ins);
    dec = '0;
    dec.illegal = 1'b1;
    add_row("illegal_32", ins, dec, '0, 1'b0, '0, 1'b0, 0, ctrl_pkg::PC_EXC,
            6'd2, ins.instr, 4'b0110, 1'b0);
    random_instr(1'b1, ins);
    add_row("illegal_16", ins, dec, '0, 1'b0, '0, 1'b0, 0, ctrl_pkg::PC_EXC,
            6'd2, {16'h0, ins.instr_c}, 4'b0110, 1'b0);
    random_instr(1'b0, ins);
    dec = '0;
    dec.ecall = 1'b1;
    add_row("ecall", ins, dec, '0, 1'b0, '0, 1'b0, 0, ctrl_pkg::PC_EXC,
            6'd11, '0, 4'b0110, 1'b0);
    random_instr(1'b0, ins);
    dec = '0;
    dec.ebrk = 1'b1;
    add_row("ebreak", ins, dec, '0, 1'b0, '0, 1'b0, 0, ctrl_pkg::PC_EXC,
            6'd3, '0, 4'b0110, 1'b0);
    random_instr(1'b0, ins);
    dec = '0;
    dec.fetch_err = 1'b1;
    dec.illegal   = 1'b1;
    add_row("fetch_over_illegal", ins, dec, '0, 1'b0, '0, 1'b0, 0, ctrl_pkg::PC_EXC,
            6'd1, ins.pc, 4'b0110, 1'b0);
    // LSU faults come without an instruction in ID
    lsu      = '0;
    lsu.load = 1'b1;
    lsu.addr = $random(seed);
    add_row("load_fault", '0, '0, '0, 1'b0, lsu, 1'b0, 0, ctrl_pkg::PC_EXC,
            6'd5, lsu.addr, 4'b0010, 1'b0);
    lsu.store = 1'b1;
    lsu.addr  = $random(seed);
    add_row("store_over_load", '0, '0, '0, 1'b0, lsu, 1'b0, 0, ctrl_pkg::PC_EXC,
            6'd7, lsu.addr, 4'b0010, 1'b0);
    random_instr(1'b0, ins);
    dec = '0;
    dec.illegal = 1'b1;
    lsu.load    = 1'b0;
    add_row("id_over_lsu", ins, dec, '0, 1'b0, lsu, 1'b0, 0, ctrl_pkg::PC_EXC,
            6'd2, ins.instr, 4'b0110, 1'b0);
    // fast 9 outranks fast 3, taken only once the stall ends
    irq = '0;
    irq.fast[3] = 1'b1;
    irq.fast[9] = 1'b1;
    irq.timer   = 1'b1;
    add_row("fast_irq_stalled", '0, '0, irq, 1'b1, '0, 1'b1, 3, ctrl_pkg::PC_EXC,
            6'b11_1001, '0, 4'b1010, 1'b0);
    irq = '0;
    irq.external = 1'b1;
    irq.software = 1'b1;
    irq.timer    = 1'b1;
    add_row("external_irq", '0, '0, irq, 1'b1, '0, 1'b0, 0, ctrl_pkg::PC_EXC,
            6'b10_1011, '0, 4'b1010, 1'b0);
    irq = '0;
    irq.software = 1'b1;
    add_row("software_irq", '0, '0, irq, 1'b1, '0, 1'b0, 0, ctrl_pkg::PC_EXC,
            6'b10_0011, '0, 4'b1010, 1'b0);
    // MIE low lets only nm through
    irq = '0;
    irq.nm    = 1'b1;
    irq.timer = 1'b1;
    add_row("nmi_mie_low", '0, '0, irq, 1'b0, '0, 1'b0, 0, ctrl_pkg::PC_EXC,
            6'b11_1111, '0, 4'b1010, 1'b1);
    // timer masked in NMI mode for the quiet cycles, then mret
    random_instr(1'b0, ins);
    dec = '0;
    dec.mret = 1'b1;
    irq = '0;
    irq.timer = 1'b1;
    add_row("masked_then_mret", ins, dec, irq, 1'b1, '0, 1'b0, 3, ctrl_pkg::PC_ERET,
            6'd0, '0, 4'b0001, 1'b0);
  endtask

  ////////////////////////////////////////
  // row execution
  ////////////////////////////////////////

  task automatic run_row(int r);
    bit seen;
    seen = 0;
    @(posedge clk_i);
    instr_i    <= row_instr[r];
    irqs_i     <= row_irqs[r];
    mie_i      <= row_mie[r];
    // quiet phase: no redirect may happen yet
    for (int q = 0; q < row_quiet[r]; q++) begin
      stall_id_i <= row_stall[r];
      @(negedge clk_i);
      check_flag(row_name[r], "pc_set while quiet", 1'b0, pc_o.set);
      if (row_stall[r]) begin
        check_flag(row_name[r], "id_in_ready in stall", 1'b0, id_in_ready_o);
        // the stalled instruction stays valid in ID
        check_flag(row_name[r], "instr_valid_clear in stall", 1'b0, instr_valid_clear_o);
      end
      @(posedge clk_i);
    end
    stall_id_i <= 1'b0;
    dec_i      <= row_dec[r];
    lsu_err_i  <= row_lsu[r];
    while (!seen) begin
      @(negedge clk_i);
      if (pc_o.set) begin
        seen = 1;
      end else begin
        @(posedge clk_i);
        // LSU errors are one-cycle strobes
        lsu_err_i <= '0;
      end
    end
    check_pc(row_name[r], row_pc[r], pc_o.mux);
    check_cause(row_name[r], row_cause[r], csr_o.cause);
    check_mtval(row_name[r], row_mtval[r], csr_o.mtval);
    check_flag(row_name[r], "save_if", row_flags[r][3], csr_o.save_if);
    check_flag(row_name[r], "save_id", row_flags[r][2], csr_o.save_id);
    check_flag(row_name[r], "save_cause", row_flags[r][1], csr_o.save_cause);
    check_flag(row_name[r], "restore_mret", row_flags[r][0], csr_o.restore_mret);
    if (row_flags[r][3]) begin
      check_flag(row_name[r], "irq vector", 1'b1, pc_o.exc_mux == ctrl_pkg::EXC_PC_IRQ);
    end
    @(posedge clk_i);
    drive_idle();
    @(negedge clk_i);
    check_flag(row_name[r], "nmi_mode", row_nmi[r], nmi_mode_o);
  endtask

  // WFI, sleep, then wake on a raw timer line with MIE low
  task automatic sleep_and_wake();
    ctrl_pkg::instr_t ins;
    random_instr(1'b0, ins);
    @(posedge clk_i);
    instr_i   <= ins;
    dec_i     <= '0;
    dec_i.wfi <= 1'b1;
    repeat (2) @(posedge clk_i);
    drive_idle();
    for (int i = 0; i < 4; i++) begin
      @(negedge clk_i);
      check_flag("wfi_sleep", "ctrl_busy", 1'b0, ctrl_busy_o);
      check_flag("wfi_sleep", "instr_req", 1'b0, instr_req_o);
    end
    @(posedge clk_i);
    irqs_i.timer <= 1'b1;
    @(negedge clk_i);
    check_flag("wfi_wake", "ctrl_busy", 1'b1, ctrl_busy_o);
    while (!instr_req_o) begin
      @(negedge clk_i);
    end
    check_flag("wfi_wake", "pc_set", 1'b0, pc_o.set);
    @(posedge clk_i);
    drive_idle();
  endtask

  initial begin
    clk_i  = 1'b0;
    rst_ni = 1'b0;
    drive_idle();
    build_table();
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;
    // RESET then BOOT_SET
    @(negedge clk_i);
    check_pc("boot_0", ctrl_pkg::PC_BOOT, pc_o.mux);
    check_flag("boot_0", "pc_set", 1'b1, pc_o.set);
    check_flag("boot_0", "instr_req", 1'b0, instr_req_o);
    check_flag("boot_0", "csr strobes", 1'b0, |{csr_o.save_if, csr_o.save_id,
               csr_o.save_cause, csr_o.restore_mret});
    check_flag("boot_0", "nmi_mode", 1'b0, nmi_mode_o);
    check_flag("boot_0", "flush_id", 1'b0, flush_id_o);
    @(negedge clk_i);
    check_pc("boot_1", ctrl_pkg::PC_BOOT, pc_o.mux);
    check_flag("boot_1", "pc_set", 1'b1, pc_o.set);
    check_flag("boot_1", "instr_req", 1'b1, instr_req_o);
    check_flag("boot_1", "save_cause", 1'b0, csr_o.save_cause);
    for (int r = 0; r < nrows; r++) begin
      run_row(r);
    end
    sleep_and_wake();
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

// File: trap_detect.sv
////////////////////////////////////////
// ID stage exception ranking and
// interrupt decision with cause encoding
////////////////////////////////////////

`timescale 1ns/1ps
`include "ctrl_defines.svh"

module trap_detect (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  ctrl_pkg::instr_t      instr_i,
  input  ctrl_pkg::dec_flags_t  dec_i,
  input  trap_pkg::irqs_t       irqs_i,
  input  logic                  mie_i,
  input  logic                  nmi_mode_i,
  output trap_pkg::trap_rec_t   trap_o,
  output logic                  special_req_o,
  output logic                  irq_take_o,
  output trap_pkg::exc_cause_u  irq_cause_o
);

  logic fetch_err;
  logic illegal;
  logic ecall;
  logic ebrk;
  logic mret;
  logic wfi;

  // one-hot ranking of the ID exceptions
  logic fetch_prio;
  logic illegal_prio;
  logic ecall_prio;
  logic ebrk_prio;

  logic                       irq_any;
  logic [`CTRL_FAST_ID_W-1:0] fast_id;

  ////////////////////////////////////////
  // exceptions
  ////////////////////////////////////////

  // decoder flags ignore valid, qualify them here
  assign fetch_err = dec_i.fetch_err & instr_i.valid;
  assign illegal   = dec_i.illegal   & instr_i.valid;
  assign ecall     = dec_i.ecall     & instr_i.valid;
  assign ebrk      = dec_i.ebrk      & instr_i.valid;
  assign mret      = dec_i.mret      & instr_i.valid;
  assign wfi       = dec_i.wfi       & instr_i.valid;

  // anything that needs the FLUSH state
  assign special_req_o = fetch_err | illegal | ecall | ebrk | mret | wfi;

  // fetch fault first, then illegal, ecall, ebreak
  assign fetch_prio   = fetch_err;
  assign illegal_prio = illegal & ~fetch_err;
  assign ecall_prio   = ecall & ~fetch_err & ~illegal;
  assign ebrk_prio    = ebrk & ~fetch_err & ~illegal & ~ecall;

  always_comb begin
    trap_o.valid = fetch_prio | illegal_prio | ecall_prio | ebrk_prio;
    trap_o.cause = '0;
    trap_o.mtval = '0;
    if (fetch_prio) begin
      // an error in the upper half of a 32-bit fetch points past the pc
      trap_o.cause = trap_pkg::CAUSE_FETCH_FAULT;
      trap_o.mtval = dec_i.fetch_err_plus2 ? instr_i.pc + `CTRL_XLEN'(2) : instr_i.pc;
    end else if (illegal_prio) begin
      trap_o.cause = trap_pkg::CAUSE_ILLEGAL;
      trap_o.mtval = instr_i.is_compressed ?
                     {{(`CTRL_XLEN-16){1'b0}}, instr_i.instr_c} : instr_i.instr;
    end else if (ecall_prio) begin
      trap_o.cause = trap_pkg::CAUSE_ECALL_M;
    end else if (ebrk_prio) begin
      trap_o.cause = trap_pkg::CAUSE_BREAKPOINT;
    end
  end

  ////////////////////////////////////////
  // interrupts
  ////////////////////////////////////////

  assign irq_any = (|irqs_i.fast) | irqs_i.external | irqs_i.software | irqs_i.timer;

  // nm ignores MIE, nothing is taken inside the NMI handler
  assign irq_take_o = ~nmi_mode_i & (irqs_i.nm | (irq_any & mie_i));

  // highest set fast line wins, later iterations override
  always_comb begin
    fast_id = '0;
    for (int i = 0; i < `CTRL_NUM_FAST; i++) begin
      if (irqs_i.fast[i]) begin
        fast_id = `CTRL_FAST_ID_W'(i);
      end
    end
  end

  always_comb begin
    if (irqs_i.nm) begin
      irq_cause_o = trap_pkg::CAUSE_IRQ_NM;
    end else if (|irqs_i.fast) begin
      // fast n maps to cause 16+n
      irq_cause_o.irq_view.irq  = 1'b1;
      irq_cause_o.irq_view.fast = 1'b1;
      irq_cause_o.irq_view.id   = fast_id;
    end else if (irqs_i.external) begin
      irq_cause_o = trap_pkg::CAUSE_IRQ_EXTERNAL;
    end else if (irqs_i.software) begin
      irq_cause_o = trap_pkg::CAUSE_IRQ_SOFTWARE;
    end else begin
      irq_cause_o = trap_pkg::CAUSE_IRQ_TIMER;
    end
  end

  // any raised ID flag gives a valid exception trap ranked from the fetch fault down
  prio_onehot_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_i.valid && (dec_i.fetch_err || dec_i.illegal || dec_i.ecall || dec_i.ebrk) |->
      trap_o.valid && !trap_o.cause.exc_view.irq &&
      (!dec_i.fetch_err || trap_o.cause == trap_pkg::CAUSE_FETCH_FAULT) &&
      (!dec_i.illegal || dec_i.fetch_err || trap_o.cause == trap_pkg::CAUSE_ILLEGAL));

endmodule

// File: trap_pending.sv
////////////////////////////////////////
// pending trap register for ID and LSU
// faults, merged by priority
////////////////////////////////////////

`timescale 1ns/1ps

module trap_pending (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  trap_pkg::trap_rec_t trap_i,
  input  ctrl_pkg::lsu_err_t  lsu_err_i,
  input  logic                clear_i,
  output trap_pkg::trap_rec_t pending_o
);

  trap_pkg::trap_rec_t id_q;

  logic                     load_q;
  logic                     store_q;
  logic [$bits(lsu_err_i.addr)-1:0] addr_q;

  logic                     load_any;
  logic                     store_any;
  logic [$bits(lsu_err_i.addr)-1:0] lsu_addr;

  ////////////////////////////////////////
  // capture
  ////////////////////////////////////////

  // first ID trap is kept, clear wins over a new capture
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      id_q <= '0;
    end else if (clear_i) begin
      id_q.valid <= 1'b0;
    end else if (!id_q.valid && trap_i.valid) begin
      id_q <= trap_i;
    end
  end

  // LSU strobes last a single cycle, stretch them until the FSM clears
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      load_q  <= 1'b0;
      store_q <= 1'b0;
    end else if (clear_i) begin
      load_q  <= 1'b0;
      store_q <= 1'b0;
    end else begin
      load_q  <= load_q | lsu_err_i.load;
      store_q <= store_q | lsu_err_i.store;
    end
  end

  // address of the first held LSU fault
  always_ff @(posedge clk_i) begin
    if (!clear_i && !(load_q || store_q) && (lsu_err_i.load || lsu_err_i.store)) begin
      addr_q <= lsu_err_i.addr;
    end
  end

  ////////////////////////////////////////
  // merge
  ////////////////////////////////////////

  // a strobe shows up in the same cycle so FLUSH follows the error pulse
  assign load_any  = load_q | lsu_err_i.load;
  assign store_any = store_q | lsu_err_i.store;
  assign lsu_addr  = (load_q || store_q) ? addr_q : lsu_err_i.addr;

  // ID fault, then store fault, then load fault
  always_comb begin
    pending_o = id_q;
    if (!id_q.valid) begin
      pending_o.valid = store_any | load_any;
      pending_o.cause = store_any ? trap_pkg::CAUSE_STORE_FAULT : trap_pkg::CAUSE_LOAD_FAULT;
      pending_o.mtval = lsu_addr;
    end
  end

  // the merged record stays stable while a held ID trap waits for FLUSH
  hold_until_clear_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    id_q.valid && !clear_i |=> pending_o == $past(pending_o));

endmodule

// File: trap_pkg.sv
////////////////////////////////////////
// trap types: cause union, cause codes,
// interrupt lines, trap record, CSR side
////////////////////////////////////////

`include "ctrl_defines.svh"

package trap_pkg;

  // cause read as an exception
  typedef struct packed {
    logic                     irq;
    logic [`CTRL_CAUSE_W-2:0] code;
  } exc_view_t;

  // cause read as an interrupt, fast flag adds 16 to the id
  typedef struct packed {
    logic                       irq;
    logic                       fast;
    logic [`CTRL_FAST_ID_W-1:0] id;
  } irq_view_t;

  typedef union packed {
    exc_view_t exc_view;
    irq_view_t irq_view;
  } exc_cause_u;

  ////////////////////////////////////////
  // cause codes
  ////////////////////////////////////////

  localparam logic [`CTRL_CAUSE_W-1:0] CAUSE_FETCH_FAULT  = {1'b0, 5'd1};
  localparam logic [`CTRL_CAUSE_W-1:0] CAUSE_ILLEGAL      = {1'b0, 5'd2};
  localparam logic [`CTRL_CAUSE_W-1:0] CAUSE_BREAKPOINT   = {1'b0, 5'd3};
  localparam logic [`CTRL_CAUSE_W-1:0] CAUSE_LOAD_FAULT   = {1'b0, 5'd5};
  localparam logic [`CTRL_CAUSE_W-1:0] CAUSE_STORE_FAULT  = {1'b0, 5'd7};
  localparam logic [`CTRL_CAUSE_W-1:0] CAUSE_ECALL_M      = {1'b0, 5'd11};

  // interrupts carry the irq flag in the top bit
  localparam logic [`CTRL_CAUSE_W-1:0] CAUSE_IRQ_SOFTWARE = {1'b1, 5'd3};
  localparam logic [`CTRL_CAUSE_W-1:0] CAUSE_IRQ_TIMER    = {1'b1, 5'd7};
  localparam logic [`CTRL_CAUSE_W-1:0] CAUSE_IRQ_EXTERNAL = {1'b1, 5'd11};
  localparam logic [`CTRL_CAUSE_W-1:0] CAUSE_IRQ_NM       = {1'b1, 5'd31};

  // raw interrupt lines, nm on top
  typedef struct packed {
    logic                      nm;
    logic [`CTRL_NUM_FAST-1:0] fast;
    logic                      external;
    logic                      software;
    logic                      timer;
  } irqs_t;

  // one trap with its cause and mtval
  typedef struct packed {
    logic                  valid;
    exc_cause_u            cause;
    logic [`CTRL_XLEN-1:0] mtval;
  } trap_rec_t;

  // strobes and data towards the CSR file
  typedef struct packed {
    logic                  save_if;
    logic                  save_id;
    logic                  save_cause;
    logic                  restore_mret;
    exc_cause_u            cause;
    logic [`CTRL_XLEN-1:0] mtval;
  } csr_ctrl_t;

endpackage
